/* uf_pkg.sv */
package uf_pkg;

    // chain size
    localparam int NUM_UNITS      = 8;
    localparam int NUM_LINKS      = NUM_UNITS + 1;  // two end links plus internal ones
    localparam int ADDRESS_WIDTH  = $clog2(NUM_UNITS);

    // link weights
    localparam int MAX_WEIGHT     = 3;
    localparam int LINK_BIT_WIDTH = $clog2(MAX_WEIGHT + 1);

    localparam int ROUND_WIDTH    = 3;

    // shared down-counter for grow rounds and merge cycles
    localparam int COUNT_WIDTH    = (ROUND_WIDTH > ADDRESS_WIDTH) ? ROUND_WIDTH : ADDRESS_WIDTH;

    typedef enum logic [2:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_PARAMETERS_LOADING  = 3'd1,
        STAGE_MEASUREMENT_LOADING = 3'd2,
        STAGE_GROW                = 3'd3,
        STAGE_MERGE               = 3'd4,
        STAGE_REPORT              = 3'd5
    } stage_t;

    typedef enum logic [1:0] {
        BC_INTERNAL = 2'd0,  // vertex on both sides
        BC_BOUNDARY = 2'd1,  // vertex on a side only
        BC_ABSENT   = 2'd2   // never grows
    } boundary_t;

    typedef struct packed {
        logic [LINK_BIT_WIDTH-1:0] weight;
        boundary_t                 bc;
    } link_cfg_t;

    // what a vertex shows its links
    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] root;
        logic                     touches_boundary;
    } exposed_data_t;

    typedef struct packed {
        logic      [NUM_UNITS-1:0]   defects;
        link_cfg_t [NUM_LINKS-1:0]   links;
        logic      [ROUND_WIDTH-1:0] grow_rounds;
    } decode_req_t;

    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] root;
        logic                     touches_boundary;
    } unit_result_t;

endpackage

/* neighbor_link.sv */
`timescale 1ns/10ps

module neighbor_link (
    input  logic                  clk,
    input  logic                  reset,
    input  uf_pkg::stage_t        global_stage,
    input  uf_pkg::link_cfg_t     cfg_in,

    input  logic                  a_increase,
    input  logic                  b_increase,

    input  uf_pkg::exposed_data_t a_input_data,
    input  uf_pkg::exposed_data_t b_input_data,
    output uf_pkg::exposed_data_t a_output_data,  // data from the b vertex
    output uf_pkg::exposed_data_t b_output_data,  // data from the a vertex

    output logic                  fully_grown,
    output logic                  is_boundary
);
    import uf_pkg::*;

    link_cfg_t                 cfg;          // weight and boundary condition in use
    logic [LINK_BIT_WIDTH-1:0] growth;
    logic [LINK_BIT_WIDTH:0]   sum;          // spare top bit, add never wraps
    logic [LINK_BIT_WIDTH-1:0] next_growth;

    // configuration is taken once per decode
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '{weight: '0, bc: BC_ABSENT};
        end else if (global_stage == STAGE_PARAMETERS_LOADING) begin
            cfg <= cfg_in;
        end
    end

    // which sides push growth depends on the boundary condition
    always_comb begin
        case (cfg.bc)
            BC_INTERNAL: begin
                sum = {1'b0, growth} + a_increase + b_increase;
            end
            BC_BOUNDARY: begin
                sum = {1'b0, growth} + a_increase;  // far side is the code edge
            end
            default: begin
                sum = '0;  // absent link stays at zero
            end
        endcase

        // saturate at the weight
        if (sum > cfg.weight) begin
            next_growth = cfg.weight;
        end else begin
            next_growth = sum[LINK_BIT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            growth <= '0;  // fresh start for every decode
        end else begin
            growth <= next_growth;
        end
    end

    // a zero weight link counts as grown right after loading
    assign fully_grown = (cfg.bc != BC_ABSENT) && (growth >= cfg.weight);
    assign is_boundary = (cfg.bc == BC_BOUNDARY);

    // roots and flags only cross between two real vertices
    assign a_output_data = (cfg.bc == BC_INTERNAL) ? b_input_data : '0;
    assign b_output_data = (cfg.bc == BC_INTERNAL) ? a_input_data : '0;

endmodule

/* processing_unit.sv */
`timescale 1ns/10ps

module processing_unit #(
    parameter int ADDRESS = 0  // own vertex address
) (
    input  logic                  clk,
    input  logic                  reset,
    input  uf_pkg::stage_t        global_stage,
    input  logic                  defect_in,

    // link toward lower addresses
    input  logic                  left_grown,
    input  logic                  left_is_boundary,
    input  uf_pkg::exposed_data_t left_data,

    // link toward higher addresses
    input  logic                  right_grown,
    input  logic                  right_is_boundary,
    input  uf_pkg::exposed_data_t right_data,

    output logic                  increase,
    output uf_pkg::exposed_data_t exposed
);
    import uf_pkg::*;

    logic                     defect;
    logic [ADDRESS_WIDTH-1:0] root;
    logic                     touches_boundary;
    logic [ADDRESS_WIDTH-1:0] next_root;
    logic                     next_touches_boundary;

    // one step of the min-root merge over both links
    always_comb begin
        next_root             = root;
        next_touches_boundary = touches_boundary;

        if (left_grown) begin
            if (left_is_boundary) begin
                next_touches_boundary = 1'b1;  // grown into the code edge
            end else begin
                if (left_data.root < next_root) begin
                    next_root = left_data.root;
                end
                next_touches_boundary = next_touches_boundary | left_data.touches_boundary;
            end
        end

        if (right_grown) begin
            if (right_is_boundary) begin
                next_touches_boundary = 1'b1;
            end else begin
                if (right_data.root < next_root) begin
                    next_root = right_data.root;
                end
                next_touches_boundary = next_touches_boundary | right_data.touches_boundary;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            defect           <= 1'b0;
            root             <= ADDRESS_WIDTH'(ADDRESS);
            touches_boundary <= 1'b0;
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            defect           <= defect_in;
            root             <= ADDRESS_WIDTH'(ADDRESS);  // every vertex starts as its own root
            touches_boundary <= 1'b0;
        end else if (global_stage == STAGE_MERGE) begin
            root             <= next_root;
            touches_boundary <= next_touches_boundary;
        end
    end

    // only defects push growth
    assign increase = defect && (global_stage == STAGE_GROW);

    assign exposed = '{root: root, touches_boundary: touches_boundary};

endmodule

/* stage_controller.sv */
`timescale 1ns/10ps

module stage_controller (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           req,
    input  logic [uf_pkg::ROUND_WIDTH-1:0] grow_rounds,
    output uf_pkg::stage_t                 global_stage,
    output logic                           ack
);
    import uf_pkg::*;

    stage_t                 next_stage;
    logic [COUNT_WIDTH-1:0] count;       // cycles left in grow or merge, minus one
    logic [COUNT_WIDTH-1:0] next_count;

    always_comb begin
        next_stage = global_stage;
        next_count = count;

        case (global_stage)
            STAGE_IDLE: begin
                // wait for the previous ack to clear before a new decode
                if (req && !ack) begin
                    next_stage = STAGE_PARAMETERS_LOADING;
                end
            end

            STAGE_PARAMETERS_LOADING: begin
                next_stage = STAGE_MEASUREMENT_LOADING;
            end

            STAGE_MEASUREMENT_LOADING: begin
                if (grow_rounds == '0) begin
                    next_stage = STAGE_MERGE;  // no growth at all
                    next_count = COUNT_WIDTH'(NUM_UNITS - 1);
                end else begin
                    next_stage = STAGE_GROW;
                    next_count = COUNT_WIDTH'(grow_rounds - 1'b1);
                end
            end

            STAGE_GROW: begin
                if (count == '0) begin
                    next_stage = STAGE_MERGE;
                    next_count = COUNT_WIDTH'(NUM_UNITS - 1);  // enough to cross the chain
                end else begin
                    next_count = count - 1'b1;
                end
            end

            STAGE_MERGE: begin
                if (count == '0) begin
                    next_stage = STAGE_REPORT;
                end else begin
                    next_count = count - 1'b1;
                end
            end

            STAGE_REPORT: begin
                // hold the result until the host lets go
                if (!req) begin
                    next_stage = STAGE_IDLE;
                end
            end

            default: begin
                next_stage = STAGE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage <= STAGE_IDLE;
            count        <= '0;
        end else begin
            global_stage <= next_stage;
            count        <= next_count;
        end
    end

    // one cycle behind the report state on both edges
    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= (global_stage == STAGE_REPORT);
        end
    end

endmodule

/* decoder_chain.sv */
`timescale 1ns/10ps

module decoder_chain (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        req,
    input  uf_pkg::decode_req_t                         req_data,
    output logic                                        ack,
    output uf_pkg::unit_result_t [uf_pkg::NUM_UNITS-1:0] result
);
    import uf_pkg::*;

    stage_t                        global_stage;

    logic          [NUM_UNITS-1:0] unit_increase;
    exposed_data_t [NUM_UNITS-1:0] unit_exposed;

    logic          [NUM_LINKS-1:0] link_a_increase;
    logic          [NUM_LINKS-1:0] link_b_increase;
    exposed_data_t [NUM_LINKS-1:0] link_a_input;
    exposed_data_t [NUM_LINKS-1:0] link_b_input;
    exposed_data_t [NUM_LINKS-1:0] link_a_output;
    exposed_data_t [NUM_LINKS-1:0] link_b_output;
    logic          [NUM_LINKS-1:0] link_grown;
    logic          [NUM_LINKS-1:0] link_boundary;

    stage_controller u_controller (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .grow_rounds  (req_data.grow_rounds),
        .global_stage (global_stage),
        .ack          (ack)
    );

    // link i sits between vertex i-1 and vertex i
    for (genvar l = 0; l < NUM_LINKS; l++) begin : g_link
        if (l == 0) begin : g_left_end
            assign link_a_increase[l] = unit_increase[0];
            assign link_a_input[l]    = unit_exposed[0];
            assign link_b_increase[l] = 1'b0;  // no vertex past the end
            assign link_b_input[l]    = '0;
        end else if (l == NUM_UNITS) begin : g_right_end
            assign link_a_increase[l] = unit_increase[NUM_UNITS-1];
            assign link_a_input[l]    = unit_exposed[NUM_UNITS-1];
            assign link_b_increase[l] = 1'b0;
            assign link_b_input[l]    = '0;
        end else begin : g_internal
            assign link_a_increase[l] = unit_increase[l-1];
            assign link_a_input[l]    = unit_exposed[l-1];
            assign link_b_increase[l] = unit_increase[l];
            assign link_b_input[l]    = unit_exposed[l];
        end

        neighbor_link u_link (
            .clk           (clk),
            .reset         (reset),
            .global_stage  (global_stage),
            .cfg_in        (req_data.links[l]),
            .a_increase    (link_a_increase[l]),
            .b_increase    (link_b_increase[l]),
            .a_input_data  (link_a_input[l]),
            .b_input_data  (link_b_input[l]),
            .a_output_data (link_a_output[l]),
            .b_output_data (link_b_output[l]),
            .fully_grown   (link_grown[l]),
            .is_boundary   (link_boundary[l])
        );
    end

    for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
        processing_unit #(
            .ADDRESS (u)
        ) u_unit (
            .clk               (clk),
            .reset             (reset),
            .global_stage      (global_stage),
            .defect_in         (req_data.defects[u]),
            .left_grown        (link_grown[u]),
            .left_is_boundary  (link_boundary[u]),
            .left_data         ((u == 0) ? link_a_output[u] : link_b_output[u]),  // end link faces a
            .right_grown       (link_grown[u+1]),
            .right_is_boundary (link_boundary[u+1]),
            .right_data        (link_a_output[u+1]),
            .increase          (unit_increase[u]),
            .exposed           (unit_exposed[u])
        );

        assign result[u] = '{root:             unit_exposed[u].root,
                             touches_boundary: unit_exposed[u].touches_boundary};
    end

endmodule

/* tb_decoder_ref.svh */
`ifndef TB_DECODER_REF_SVH
`define TB_DECODER_REF_SVH

// expected roots and boundary flags for one request
function automatic result_vec_t decode_ref(input decode_req_t r);
    result_vec_t          res;
    logic [NUM_LINKS-1:0] grown;
    logic [NUM_UNITS-1:0] edge_touch;  // vertex owns a grown boundary link
    int                   pushes;
    int                   growth;
    int                   a_vertex;
    int                   start;

    // growth per link, capped at its weight
    for (int l = 0; l < NUM_LINKS; l++) begin
        a_vertex = (l == 0) ? 0 : l - 1;
        pushes   = int'(r.defects[a_vertex]);
        if (r.links[l].bc == BC_INTERNAL && l > 0 && l < NUM_UNITS) begin
            pushes += int'(r.defects[l]);
        end
        growth = int'(r.grow_rounds) * pushes;
        if (growth > int'(r.links[l].weight)) begin
            growth = int'(r.links[l].weight);
        end
        grown[l] = (r.links[l].bc != BC_ABSENT) && (growth >= int'(r.links[l].weight));
    end

    // clusters are runs of vertices joined by grown internal links
    start = 0;
    for (int u = 0; u < NUM_UNITS; u++) begin
        if (u == 0 || !(grown[u] && r.links[u].bc == BC_INTERNAL)) begin
            start = u;  // new cluster starts here
        end
        res[u].root   = ADDRESS_WIDTH'(start);
        edge_touch[u] = (grown[u] && r.links[u].bc == BC_BOUNDARY) ||
                        (grown[u+1] && r.links[u+1].bc == BC_BOUNDARY);
    end

    for (int u = 0; u < NUM_UNITS; u++) begin
        res[u].touches_boundary = 1'b0;
        for (int v = 0; v < NUM_UNITS; v++) begin
            if (res[v].root == res[u].root && edge_touch[v]) begin
                res[u].touches_boundary = 1'b1;
            end
        end
    end

    return res;
endfunction

`endif

/* tb_decoder_chain.sv */
`timescale 1ns/10ps

module tb_decoder_chain;
    import uf_pkg::*;

    typedef unit_result_t [NUM_UNITS-1:0] result_vec_t;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_REQUESTS    = 51;
    localparam int HOLD_CYCLES     = 5;
    // req seen to ack high at the largest round count
    localparam int MAX_LATENCY     = 2 + (2 ** ROUND_WIDTH - 1) + NUM_UNITS + 1;
    localparam int ACK_TIMEOUT     = 2 * MAX_LATENCY;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (MAX_LATENCY + HOLD_CYCLES + 8) + 200;

    logic        clk;
    logic        reset;
    logic        req;
    decode_req_t req_data;
    logic        ack;
    result_vec_t result;

    decode_req_t req_queue[$];  // requests still to be compared
    result_vec_t got_queue[$];

    int    error_count;
    int    check_count;
    int    tests_run;
    int    tests_failed;
    int    test_errors_start;
    string test_name;

    decode_req_t cmp_req;
    result_vec_t cmp_got;
    result_vec_t cmp_exp;

    `include "tb_decoder_ref.svh"

    decoder_chain UUT (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .result   (result)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    // every link at one weight with boundary end links
    function automatic decode_req_t base_req(input int weight, input int rounds);
        decode_req_t r;
        r.defects = '0;
        for (int l = 0; l < NUM_LINKS; l++) begin
            r.links[l].weight = LINK_BIT_WIDTH'(weight);
            r.links[l].bc     = (l == 0 || l == NUM_UNITS) ? BC_BOUNDARY : BC_INTERNAL;
        end
        r.grow_rounds = ROUND_WIDTH'(rounds);
        return r;
    endfunction

    function automatic decode_req_t random_req();
        decode_req_t r;
        r.defects = NUM_UNITS'($urandom & $urandom);  // sparse defects
        for (int l = 0; l < NUM_LINKS; l++) begin
            r.links[l].weight = LINK_BIT_WIDTH'($urandom_range(MAX_WEIGHT, 0));
            if (l == 0 || l == NUM_UNITS) begin
                r.links[l].bc = ($urandom_range(3, 0) == 0) ? BC_ABSENT : BC_BOUNDARY;
            end else begin
                r.links[l].bc = ($urandom_range(5, 0) == 0) ? BC_ABSENT : BC_INTERNAL;
            end
        end
        r.grow_rounds = ROUND_WIDTH'($urandom_range(4, 0));
        return r;
    endfunction

    // one full four-phase handshake with req optionally held past ack
    task automatic run_decode(input decode_req_t d, input int hold);
        result_vec_t got;
        int          waited;

        @(posedge clk);
        req      <= 1'b1;
        req_data <= d;
        waited = 0;
        @(negedge clk);
        while (!ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            error_count++;
            $display("no ack from the DUT within %0d cycles of req", ACK_TIMEOUT);
            @(posedge clk);
            req <= 1'b0;
            return;
        end
        got = result;
        req_queue.push_back(d);
        got_queue.push_back(got);

        repeat (hold) begin
            @(negedge clk);
            check_value("ack", 64'(ack), 64'(1));
            check_value("result", 64'(result), 64'(got));  // must not move
        end

        @(posedge clk);
        req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            error_count++;
            $display("ack stayed high after req was dropped");
        end
    endtask

    // compares each recorded result against the reference model
    always @(posedge clk) begin
        while (got_queue.size() > 0) begin
            cmp_req = req_queue.pop_front();
            cmp_got = got_queue.pop_front();
            cmp_exp = decode_ref(cmp_req);
            for (int u = 0; u < NUM_UNITS; u++) begin
                check_value($sformatf("result[%0d].root", u),
                            64'(cmp_got[u].root), 64'(cmp_exp[u].root));
                check_value($sformatf("result[%0d].touches_boundary", u),
                            64'(cmp_got[u].touches_boundary),
                            64'(cmp_exp[u].touches_boundary));
            end
        end
    end

    task automatic begin_test(input string name);
        test_name         = name;
        test_errors_start = error_count;
    endtask

    task automatic end_test();
        int errors;
        while (got_queue.size() != 0) begin
            @(negedge clk);
        end
        errors = error_count - test_errors_start;
        tests_run++;
        if (errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors);
        end
    endtask

    initial begin
        decode_req_t d;

        void'($urandom(32'h5067_5049));
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        req          = 1'b0;
        req_data     = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        begin_test("reset and empty syndrome");
        @(negedge clk);
        check_value("ack", 64'(ack), 64'(0));
        run_decode(base_req(2, 1), 0);
        end_test();

        begin_test("adjacent pair");
        d                 = base_req(2, 1);
        d.links[4].weight = LINK_BIT_WIDTH'(1);  // only the link between the pair fills
        d.defects[3]      = 1'b1;
        d.defects[4]      = 1'b1;
        run_decode(d, 0);
        end_test();

        begin_test("boundary flag");
        d             = base_req(1, 1);
        d.defects[0]  = 1'b1;
        d.defects[7]  = 1'b1;
        d.links[8].bc = BC_ABSENT;  // right cluster would grow into the edge here
        run_decode(d, 0);
        end_test();

        begin_test("zero weight, absent link, zero rounds");
        run_decode(base_req(0, 0), 0);
        d             = base_req(0, 0);
        d.links[4].bc = BC_ABSENT;
        run_decode(d, 0);
        d             = base_req(3, 7);
        d.defects     = '1;
        d.links[4].bc = BC_ABSENT;  // split holds at saturation
        run_decode(d, 0);
        d         = base_req(1, 0);
        d.defects = NUM_UNITS'(8'h5a);
        run_decode(d, 0);
        end_test();

        begin_test("random requests");
        repeat (40) begin
            run_decode(random_req(), 0);
        end
        end_test();

        begin_test("handshake hold and back to back");
        run_decode(random_req(), HOLD_CYCLES);
        repeat (3) begin
            run_decode(random_req(), 0);
        end
        end_test();

        repeat (2) @(negedge clk);
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
uf_pkg.sv
neighbor_link.sv
processing_unit.sv
stage_controller.sv
decoder_chain.sv
tb_decoder_chain.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
    -f filelist.f \
    --top-module tb_decoder_chain \
    -o tb_decoder_chain_sim

./obj_dir/tb_decoder_chain_sim | tee "$LOG"

if grep -qx "STATUS: PASS" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
